// ==== verilog/fifo_params.svh ====
`ifndef FIFO_PARAMS_SVH
`define FIFO_PARAMS_SVH

// Bits per data word.
`define FIFO_DATA_WIDTH 8

// Number of entries. Must be a power of two for the Gray pointers to wrap cleanly.
`define FIFO_DEPTH 16

// log2 of FIFO_DEPTH. Pointers carry one more bit for the wrap.
`define FIFO_ADDR_WIDTH 4

// Write-side used count at or above which afull is set.
`define FIFO_AFULL 15

// Read-side used count at or below which aempty is set.
`define FIFO_AEMPTY 1

`endif

// ==== verilog/fifo_pkg.sv ====
`include "fifo_params.svh"

package fifo_pkg;

  typedef logic [`FIFO_DATA_WIDTH-1:0] data_t;
  typedef logic [`FIFO_ADDR_WIDTH-1:0] addr_t;
  typedef logic [`FIFO_ADDR_WIDTH:0]   ptr_t;  // Top bit is the wrap bit.

  typedef struct packed {
    logic full;
    logic afull;
  } wr_status_t;

  typedef struct packed {
    logic empty;
    logic aempty;
  } rd_status_t;

  function automatic ptr_t bin2gray(input ptr_t bin);
    return bin ^ (bin >> 1);
  endfunction

  // Each binary bit is the XOR of all Gray bits at or above it.
  function automatic ptr_t gray2bin(input ptr_t gray);
    ptr_t bin;
    bin[`FIFO_ADDR_WIDTH] = gray[`FIFO_ADDR_WIDTH];
    for (int i = `FIFO_ADDR_WIDTH - 1; i >= 0; i--) begin
      bin[i] = bin[i+1] ^ gray[i];
    end
    return bin;
  endfunction

endpackage

// ==== verilog/gray_sync.sv ====
`timescale 1ns/1ps

module gray_sync (
  input  logic           clk,
  input  logic           rst_n,
  input  fifo_pkg::ptr_t ptr_in,
  output fifo_pkg::ptr_t ptr_out
);
  import fifo_pkg::*;

  ptr_t ptr_meta;  // The first stage may go metastable.

  // The source changes one bit per step, so a late sample only lags by one count.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ptr_meta <= '0;
      ptr_out  <= '0;
    end else begin
      ptr_meta <= ptr_in;
      ptr_out  <= ptr_meta;
    end
  end

endmodule

// ==== verilog/fifo_wr_ctrl.sv ====
`timescale 1ns/1ps
`include "fifo_params.svh"

module fifo_wr_ctrl (
  input  logic                 wr_clk,
  input  logic                 wr_rst_n,
  input  logic                 wr_en,
  input  fifo_pkg::ptr_t       rd_ptr_gray_sync,
  output fifo_pkg::ptr_t       wr_ptr_gray,
  output logic                 ram_wr_en,
  output fifo_pkg::addr_t      ram_wr_addr,
  output fifo_pkg::wr_status_t wr_status
);
  import fifo_pkg::*;

  logic       wr_push;
  ptr_t       wr_ptr_bin;
  ptr_t       wr_ptr_bin_next;
  ptr_t       wr_ptr_gray_next;
  ptr_t       rd_ptr_bin_sync;
  ptr_t       rd_ptr_full_cmp;
  ptr_t       used_next;
  wr_status_t wr_status_next;

  assign wr_push = wr_en && !wr_status.full;  // A push while full is dropped.

  assign wr_ptr_bin_next  = wr_ptr_bin + ptr_t'(wr_push);
  assign wr_ptr_gray_next = bin2gray(wr_ptr_bin_next);

  // The read pointer lags by the synchronizer, so this count never underestimates.
  assign rd_ptr_bin_sync = gray2bin(rd_ptr_gray_sync);
  assign used_next       = wr_ptr_bin_next - rd_ptr_bin_sync;

  // Full in Gray form means the top two bits differ and the rest match.
  assign rd_ptr_full_cmp = {~rd_ptr_gray_sync[`FIFO_ADDR_WIDTH -: 2],
                            rd_ptr_gray_sync[`FIFO_ADDR_WIDTH-2:0]};

  always_comb begin
    wr_status_next.full  = (wr_ptr_gray_next == rd_ptr_full_cmp);
    wr_status_next.afull = (used_next >= `FIFO_AFULL);
  end

  always_ff @(posedge wr_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      wr_ptr_bin  <= '0;
      wr_ptr_gray <= '0;
    end else begin
      wr_ptr_bin  <= wr_ptr_bin_next;
      wr_ptr_gray <= wr_ptr_gray_next;  // Registered so only one bit toggles per edge.
    end
  end

  always_ff @(posedge wr_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      wr_status <= '0;
    end else begin
      wr_status <= wr_status_next;
    end
  end

  assign ram_wr_en   = wr_push;
  assign ram_wr_addr = wr_ptr_bin[`FIFO_ADDR_WIDTH-1:0];  // Wrap bit is not an address bit.

endmodule

// ==== verilog/fifo_rd_ctrl.sv ====
`timescale 1ns/1ps
`include "fifo_params.svh"

module fifo_rd_ctrl (
  input  logic                 rd_clk,
  input  logic                 rd_rst_n,
  input  logic                 rd_en,
  input  fifo_pkg::ptr_t       wr_ptr_gray_sync,
  output fifo_pkg::ptr_t       rd_ptr_gray,
  output logic                 ram_rd_en,
  output fifo_pkg::addr_t      ram_rd_addr,
  output logic                 rd_valid,
  output fifo_pkg::rd_status_t rd_status
);
  import fifo_pkg::*;

  logic       rd_pop;
  ptr_t       rd_ptr_bin;
  ptr_t       rd_ptr_bin_next;
  ptr_t       rd_ptr_gray_next;
  ptr_t       wr_ptr_bin_sync;
  ptr_t       used_next;
  rd_status_t rd_status_next;

  assign rd_pop = rd_en && !rd_status.empty;  // A pop while empty is ignored.

  assign rd_ptr_bin_next  = rd_ptr_bin + ptr_t'(rd_pop);
  assign rd_ptr_gray_next = bin2gray(rd_ptr_bin_next);

  // The write pointer lags by the synchronizer, so this count never overestimates.
  assign wr_ptr_bin_sync = gray2bin(wr_ptr_gray_sync);
  assign used_next       = wr_ptr_bin_sync - rd_ptr_bin_next;

  always_comb begin
    rd_status_next.empty  = (rd_ptr_gray_next == wr_ptr_gray_sync);
    rd_status_next.aempty = (used_next <= `FIFO_AEMPTY);
  end

  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      rd_ptr_bin  <= '0;
      rd_ptr_gray <= '0;
    end else begin
      rd_ptr_bin  <= rd_ptr_bin_next;
      rd_ptr_gray <= rd_ptr_gray_next;
    end
  end

  // Empty and aempty come out of reset set.
  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      rd_status <= '{empty: 1'b1, aempty: 1'b1};
    end else begin
      rd_status <= rd_status_next;
    end
  end

  // The RAM registers the word on the same edge, so the strobe lines up with rd_data.
  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      rd_valid <= 1'b0;
    end else begin
      rd_valid <= rd_pop;
    end
  end

  assign ram_rd_en   = rd_pop;
  assign ram_rd_addr = rd_ptr_bin[`FIFO_ADDR_WIDTH-1:0];

endmodule

// ==== verilog/fifo_dual_port_ram.sv ====
`timescale 1ns/1ps
`include "fifo_params.svh"

module fifo_dual_port_ram (
  input  logic            wr_clk,
  input  logic            ram_wr_en,
  input  fifo_pkg::addr_t ram_wr_addr,
  input  fifo_pkg::data_t wr_data,
  input  logic            rd_clk,
  input  logic            rd_rst_n,
  input  logic            ram_rd_en,
  input  fifo_pkg::addr_t ram_rd_addr,
  output fifo_pkg::data_t rd_data
);
  import fifo_pkg::*;

  data_t mem [`FIFO_DEPTH];

  always_ff @(posedge wr_clk) begin
    if (ram_wr_en) begin
      mem[ram_wr_addr] <= wr_data;
    end
  end

  // The controllers never let a read address meet a word still being written.
  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      rd_data <= '0;
    end else if (ram_rd_en) begin
      rd_data <= mem[ram_rd_addr];  // Holds its value between pops.
    end
  end

endmodule

// ==== verilog/async_fifo.sv ====
`timescale 1ns/1ps

module async_fifo (
  input  logic                 wr_clk,
  input  logic                 wr_rst_n,
  input  logic                 wr_en,
  input  fifo_pkg::data_t      wr_data,
  output fifo_pkg::wr_status_t wr_status,
  input  logic                 rd_clk,
  input  logic                 rd_rst_n,
  input  logic                 rd_en,
  output fifo_pkg::data_t      rd_data,
  output logic                 rd_valid,
  output fifo_pkg::rd_status_t rd_status
);
  import fifo_pkg::*;

  ptr_t  wr_ptr_gray;
  ptr_t  wr_ptr_gray_sync;  // Write pointer in the read domain.
  ptr_t  rd_ptr_gray;
  ptr_t  rd_ptr_gray_sync;  // Read pointer in the write domain.
  logic  ram_wr_en;
  addr_t ram_wr_addr;
  logic  ram_rd_en;
  addr_t ram_rd_addr;

  fifo_wr_ctrl u_wr_ctrl (
    .wr_clk           (wr_clk),
    .wr_rst_n         (wr_rst_n),
    .wr_en            (wr_en),
    .rd_ptr_gray_sync (rd_ptr_gray_sync),
    .wr_ptr_gray      (wr_ptr_gray),
    .ram_wr_en        (ram_wr_en),
    .ram_wr_addr      (ram_wr_addr),
    .wr_status        (wr_status)
  );

  fifo_rd_ctrl u_rd_ctrl (
    .rd_clk           (rd_clk),
    .rd_rst_n         (rd_rst_n),
    .rd_en            (rd_en),
    .wr_ptr_gray_sync (wr_ptr_gray_sync),
    .rd_ptr_gray      (rd_ptr_gray),
    .ram_rd_en        (ram_rd_en),
    .ram_rd_addr      (ram_rd_addr),
    .rd_valid         (rd_valid),
    .rd_status        (rd_status)
  );

  gray_sync u_wr2rd (
    .clk     (rd_clk),
    .rst_n   (rd_rst_n),
    .ptr_in  (wr_ptr_gray),
    .ptr_out (wr_ptr_gray_sync)
  );

  gray_sync u_rd2wr (
    .clk     (wr_clk),
    .rst_n   (wr_rst_n),
    .ptr_in  (rd_ptr_gray),
    .ptr_out (rd_ptr_gray_sync)
  );

  fifo_dual_port_ram u_ram (
    .wr_clk      (wr_clk),
    .ram_wr_en   (ram_wr_en),
    .ram_wr_addr (ram_wr_addr),
    .wr_data     (wr_data),
    .rd_clk      (rd_clk),
    .rd_rst_n    (rd_rst_n),
    .ram_rd_en   (ram_rd_en),
    .ram_rd_addr (ram_rd_addr),
    .rd_data     (rd_data)
  );

endmodule

// ==== tb/async_fifo_checker.sv ====
`timescale 1ns/1ps

module async_fifo_checker (
  input logic                 wr_clk,
  input logic                 wr_rst_n,
  input logic                 rd_clk,
  input logic                 rd_rst_n,
  input logic                 rd_en,
  input logic                 rd_valid,
  input fifo_pkg::wr_status_t wr_status,
  input fifo_pkg::rd_status_t rd_status
);

  int unsigned assert_failures = 0;

  full_implies_afull: assert property (@(posedge wr_clk) disable iff (!wr_rst_n)
    wr_status.full |-> wr_status.afull)
    else begin
      assert_failures++;
      $error("full is set without afull");
    end

  empty_implies_aempty: assert property (@(posedge rd_clk) disable iff (!rd_rst_n)
    rd_status.empty |-> rd_status.aempty)
    else begin
      assert_failures++;
      $error("empty is set without aempty");
    end

  // The strobe comes exactly one cycle after an accepted pop, and at no other time.
  valid_after_pop: assert property (@(posedge rd_clk) disable iff (!rd_rst_n)
    rd_valid |-> $past(rd_en && !rd_status.empty))
    else begin
      assert_failures++;
      $error("rd_valid without a pop in the previous cycle");
    end

  pop_gives_valid: assert property (@(posedge rd_clk) disable iff (!rd_rst_n)
    (rd_en && !rd_status.empty) |=> rd_valid)
    else begin
      assert_failures++;
      $error("accepted pop not followed by rd_valid");
    end

  no_pop_when_empty: assert property (@(posedge rd_clk) disable iff (!rd_rst_n)
    rd_status.empty |=> !rd_valid)
    else begin
      assert_failures++;
      $error("pop accepted while empty");
    end

endmodule

bind async_fifo async_fifo_checker u_checker (
  .wr_clk    (wr_clk),
  .wr_rst_n  (wr_rst_n),
  .rd_clk    (rd_clk),
  .rd_rst_n  (rd_rst_n),
  .rd_en     (rd_en),
  .rd_valid  (rd_valid),
  .wr_status (wr_status),
  .rd_status (rd_status)
);

// ==== tb/async_fifo_tb.sv ====
`timescale 1ns/1ps
`include "fifo_params.svh"

module async_fifo_tb;
  import fifo_pkg::*;

  logic       wr_clk;
  logic       wr_rst_n;
  logic       wr_en;
  data_t      wr_data;
  wr_status_t wr_status;
  logic       rd_clk;
  logic       rd_rst_n;
  logic       rd_en;
  data_t      rd_data;
  logic       rd_valid;
  rd_status_t rd_status;

  data_t       model_q[$];  // Words accepted by the FIFO and not yet read back.
  int unsigned lcg_state     = 26;
  int          words_read    = 0;
  int          data_errors   = 0;
  int          status_errors = 0;
  int          other_errors  = 0;
  int          assert_errors = 0;
  int          level_list[6] = '{0, 1, 2, 14, 15, 16};

  async_fifo u_dut (
    .wr_clk    (wr_clk),
    .wr_rst_n  (wr_rst_n),
    .wr_en     (wr_en),
    .wr_data   (wr_data),
    .wr_status (wr_status),
    .rd_clk    (rd_clk),
    .rd_rst_n  (rd_rst_n),
    .rd_en     (rd_en),
    .rd_data   (rd_data),
    .rd_valid  (rd_valid),
    .rd_status (rd_status)
  );

  // The rising edges of the two clocks never coincide.
  initial begin
    rd_clk = 1'b0;
    forever #2 rd_clk = ~rd_clk;
  end

  initial begin
    wr_clk = 1'b0;
    forever #3 wr_clk = ~wr_clk;
  end

  function automatic int unsigned lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  function automatic data_t expected_word();
    return model_q[0];  // Oldest accepted word.
  endfunction

  function automatic wr_status_t expected_wr_status(input int count);
    wr_status_t s;
    s.full  = (count >= `FIFO_DEPTH);
    s.afull = (count >= `FIFO_AFULL);
    return s;
  endfunction

  function automatic rd_status_t expected_rd_status(input int count);
    rd_status_t s;
    s.empty  = (count == 0);
    s.aempty = (count <= `FIFO_AEMPTY);
    return s;
  endfunction

  task automatic check_data(input data_t got, input data_t exp, input string name);
    if (got !== exp) begin
      $display("[ERROR] %0t ns %s: got %h, expected %h", $time, name, got, exp);
      data_errors++;
    end
  endtask

  task automatic check_wr_status(input wr_status_t got, input wr_status_t exp,
                                 input string name);
    if (got !== exp) begin
      $display("[ERROR] %0t ns %s: got %b, expected %b", $time, name, got, exp);
      status_errors++;
    end
  endtask

  task automatic check_rd_status(input rd_status_t got, input rd_status_t exp,
                                 input string name);
    if (got !== exp) begin
      $display("[ERROR] %0t ns %s: got %b, expected %b", $time, name, got, exp);
      status_errors++;
    end
  endtask

  task automatic push_words(input int count, input data_t base);
    for (int i = 0; i < count; i++) begin
      @(posedge wr_clk);
      #1;
      wr_en   = 1'b1;
      wr_data = data_t'(base + i);
    end
    @(posedge wr_clk);
    #1;
    wr_en = 1'b0;
  endtask

  // Eight quiet cycles in each domain let both pointers cross over.
  task automatic settle();
    repeat (8) @(posedge wr_clk);
    repeat (8) @(posedge rd_clk);
    #1;
  endtask

  task automatic drain_fifo(input int max_cycles);
    bit done;
    done = 1'b0;
    @(posedge rd_clk);
    #1;
    rd_en = 1'b1;
    for (int i = 0; i < max_cycles && !done; i++) begin
      @(posedge rd_clk);
      #1;
      done = (model_q.size() == 0) && rd_status.empty;
    end
    rd_en = 1'b0;
    if (!done) begin
      $display("Timeout at %0t ns: FIFO not drained after %0d read cycles", $time, max_cycles);
      other_errors++;
    end
  endtask

  task automatic read_while_empty(input int cycles, output int valid_seen);
    valid_seen = 0;
    repeat (cycles) begin
      @(posedge rd_clk);
      #1;
      rd_en = 1'b1;
      if (rd_valid) begin
        valid_seen++;
      end
    end
  endtask

  task automatic random_writer(input int cycles);
    int unsigned r;
    for (int i = 0; i < cycles; i++) begin
      @(posedge wr_clk);
      #1;
      r       = lcg_next();
      wr_en   = (r[31:28] < 4'd9);
      wr_data = r[23:16];
    end
    @(posedge wr_clk);
    #1;
    wr_en = 1'b0;
  endtask

  task automatic random_reader(input int cycles);
    int unsigned r;
    for (int i = 0; i < cycles; i++) begin
      @(posedge rd_clk);
      #1;
      r     = lcg_next();
      rd_en = (r[31:28] < 4'd5);  // Slower than the writer, so full gets hit.
    end
    @(posedge rd_clk);
    #1;
    rd_en = 1'b0;
  endtask

  // Inputs are stable at the falling edge and match what the next rising edge samples.
  always @(negedge wr_clk) begin
    if (wr_rst_n && wr_en && !wr_status.full) begin
      model_q.push_back(wr_data);
    end
  end

  always @(negedge rd_clk) begin
    if (rd_rst_n && rd_valid) begin
      if (model_q.size() == 0) begin
        $display("At %0t ns rd_valid was high with no word left in the FIFO", $time);
        other_errors++;
      end else begin
        check_data(rd_data, expected_word(), "rd_data");
        void'(model_q.pop_front());
        words_read++;
      end
    end
  end

  initial begin
    int start;
    int valid_seen;
    wr_rst_n = 1'b0;
    rd_rst_n = 1'b0;
    wr_en    = 1'b0;
    rd_en    = 1'b0;
    wr_data  = '0;
    repeat (16) @(posedge rd_clk);
    #1;
    rd_rst_n = 1'b1;
    @(posedge wr_clk);
    #1;
    wr_rst_n = 1'b1;
    settle();
    check_rd_status(rd_status, expected_rd_status(0), "rd_status");
    check_wr_status(wr_status, expected_wr_status(0), "wr_status");

    push_words(20, 8'hA0);
    settle();
    if (model_q.size() != `FIFO_DEPTH) begin
      $display("Full did not stop the writer: %0d of 20 pushes accepted", model_q.size());
      other_errors++;
    end
    check_wr_status(wr_status, expected_wr_status(model_q.size()), "wr_status");
    start = words_read;
    drain_fifo(200);
    if (words_read - start != `FIFO_DEPTH) begin
      $display("Drain after full returned %0d words", words_read - start);
      other_errors++;
    end

    start = words_read;
    read_while_empty(10, valid_seen);
    if (valid_seen != 0) begin
      $display("A pop on the empty FIFO raised rd_valid %0d times", valid_seen);
      other_errors++;
    end
    push_words(1, 8'h5A);
    drain_fifo(100);
    if (words_read - start != 1) begin
      $display("The word written after the empty pops was not read back");
      other_errors++;
    end

    foreach (level_list[i]) begin
      push_words(level_list[i] - model_q.size(), data_t'(8'h40 + 8 * i));
      settle();
      check_wr_status(wr_status, expected_wr_status(model_q.size()), "wr_status");
      check_rd_status(rd_status, expected_rd_status(model_q.size()), "rd_status");
    end
    drain_fifo(200);

    fork
      random_writer(600);
      random_reader(600);
    join
    drain_fifo(2000);
    settle();
    if (model_q.size() != 0) begin
      $display("%0d words were never read back after random traffic", model_q.size());
      other_errors++;
    end
    check_rd_status(rd_status, expected_rd_status(0), "rd_status");
    check_wr_status(wr_status, expected_wr_status(0), "wr_status");

    assert_errors = int'(u_dut.u_checker.assert_failures);
    $display("Errors: %0d data, %0d status, %0d assertion, %0d other (%0d words compared)",
             data_errors, status_errors, assert_errors, other_errors, words_read);
    if (data_errors + status_errors + assert_errors + other_errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

// ==== src.f ====
+incdir+verilog
verilog/fifo_pkg.sv
verilog/gray_sync.sv
verilog/fifo_wr_ctrl.sv
verilog/fifo_rd_ctrl.sv
verilog/fifo_dual_port_ram.sv
verilog/async_fifo.sv
tb/async_fifo_checker.sv
tb/async_fifo_tb.sv

// ==== Bender.yml ====
package:
  name: async_fifo

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/fifo_pkg.sv
      - verilog/gray_sync.sv
      - verilog/fifo_wr_ctrl.sv
      - verilog/fifo_rd_ctrl.sv
      - verilog/fifo_dual_port_ram.sv
      - verilog/async_fifo.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - tb/async_fifo_checker.sv
      - tb/async_fifo_tb.sv
